// File: rtl/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Address and data word width
`define DC_WORD_BITS 32

// One line holds 16 bytes
`define DC_LINE_BITS 128
`define DC_OFFSET_BITS 4

// Direct mapped, so sets equal lines
`define DC_N_SETS 4
`define DC_SET_BITS 2

// Address bits above set and offset
`define DC_TAG_BITS 26

// Store buffer depth, also the largest pin count a line can hold
`define DC_SB_ENTRIES 4

// One outstanding fill per set at most
`define DC_MRQ_DEPTH 4

`endif

// File: rtl/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    // Access size of a load probe or a committed store
    // Halfwords are not supported
    typedef enum logic {
        SIZE_BYTE = 1'b0,
        SIZE_WORD = 1'b1
    } mem_size_e;

    // Address or data word
    typedef logic [`DC_WORD_BITS-1:0] word_t;

    // Full cache line as moved to and from memory
    typedef logic [`DC_LINE_BITS-1:0] line_t;

endpackage

// File: rtl/dcache_ifc.sv
`timescale 1ns/1ps

// Store buffer head towards the cache
// wenable is a level, the head is valid
// store_success at an edge writes the entry and pops it
interface sb_drain_if;
    import dcache_pkg::*;

    word_t     addr;
    word_t     value;
    mem_size_e size;
    logic      wenable;
    logic      store_success;

    modport producer (
        output addr, value, size, wenable,
        input  store_success
    );

    modport consumer (
        input  addr, value, size, wenable,
        output store_success
    );
endinterface

// Line requests from the cache and in-order line returns from the port
interface line_fill_if;
    import dcache_pkg::*;

    // One-cycle request strobe with the line address
    logic  req;
    word_t req_addr;

    // One-cycle response for the oldest request
    logic  res;
    word_t res_addr;
    line_t res_data;

    modport cache (output req, req_addr, input res, res_addr, res_data);
    modport port  (input req, req_addr, output res, res_addr, res_data);
endinterface

// File: rtl/store_buffer.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module store_buffer #(
    parameter int DEPTH = `DC_SB_ENTRIES
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit,
    input  dcache_pkg::word_t     commit_addr,
    input  dcache_pkg::word_t     commit_value,
    input  dcache_pkg::mem_size_e commit_size,
    output logic                  sb_full,
    output logic                  sb_empty,
    sb_drain_if.producer          drain
);
    import dcache_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage, in program order
    word_t     addr_q  [DEPTH];
    word_t     value_q [DEPTH];
    mem_size_e size_q  [DEPTH];

    // Read and write pointers plus occupancy
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // A commit while full is lost, the pipeline must watch sb_full
    assign push = commit && !sb_full;
    // Cache accepted the head this cycle
    assign pop  = drain.wenable && drain.store_success;

    assign sb_full  = (count == CNT_W'(DEPTH));
    assign sb_empty = (count == '0);

    // Head entry is always offered to the cache
    assign drain.addr    = addr_q[head];
    assign drain.value   = value_q[head];
    assign drain.size    = size_q[head];
    assign drain.wenable = !sb_empty;

    // Pointers and count
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                // wrap at DEPTH, which need not be a power of two
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[tail]  <= commit_addr;
            value_q[tail] <= commit_value;
            size_q[tail]  <= commit_size;
        end
    end

endmodule

// File: rtl/dcache.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  dcache_pkg::word_t     addr,
    input  dcache_pkg::mem_size_e load_size,
    input  logic                  store,
    output logic                  hit,
    output logic                  store_stall,
    output dcache_pkg::word_t     read_data,
    sb_drain_if.consumer          drain,
    line_fill_if.cache            fill,
    output logic                  evict,
    output dcache_pkg::word_t     evict_addr,
    output dcache_pkg::line_t     evict_data
);
    import dcache_pkg::*;

    localparam int N     = `DC_N_SETS;
    localparam int OFF_W = `DC_OFFSET_BITS;
    localparam int SET_W = `DC_SET_BITS;
    localparam int TAG_W = `DC_TAG_BITS;
    // Counter must reach the full store buffer depth
    localparam int PIN_W = $clog2(`DC_SB_ENTRIES + 1);

    // Line state per set
    logic [TAG_W-1:0] tags    [N];
    line_t            data    [N];
    logic [N-1:0]     dirty;
    logic [PIN_W-1:0] pin_cnt [N];

    // Outstanding miss per set, with pins from early stores
    logic [N-1:0]     mrq_present;
    logic [TAG_W-1:0] mrq_tag [N];
    logic [PIN_W-1:0] mrq_pin [N];

    // Probe address fields
    logic [OFF_W-1:0] pr_off;
    logic [SET_W-1:0] pr_set;
    logic [TAG_W-1:0] pr_tag;
    // Store buffer head fields
    logic [OFF_W-1:0] sb_off;
    logic [SET_W-1:0] sb_set;
    logic [TAG_W-1:0] sb_tag;
    // Returning line fields
    logic [SET_W-1:0] res_set;
    logic [TAG_W-1:0] res_tag;

    logic       req;
    logic       mrq_match;
    logic       res_ok;
    logic       drain_ok;
    logic [N-1:0] pin_inc;
    logic [N-1:0] pin_dec;
    logic [N-1:0] mrq_inc;

    line_t      probe_line;
    logic [7:0] load_byte;
    line_t      merged;

    assign pr_off  = addr[OFF_W-1:0];
    assign pr_set  = addr[OFF_W +: SET_W];
    assign pr_tag  = addr[`DC_WORD_BITS-1 -: TAG_W];
    assign sb_off  = drain.addr[OFF_W-1:0];
    assign sb_set  = drain.addr[OFF_W +: SET_W];
    assign sb_tag  = drain.addr[`DC_WORD_BITS-1 -: TAG_W];
    assign res_set = fill.res_addr[OFF_W +: SET_W];
    assign res_tag = fill.res_addr[`DC_WORD_BITS-1 -: TAG_W];

    // No valid bit, any tag match is a hit
    assign hit = valid && (tags[pr_set] == pr_tag);

    // Fill only when the set is free of pins and of an outstanding miss
    assign req = valid && !hit && (pin_cnt[pr_set] == '0) && !mrq_present[pr_set];
    assign fill.req      = req;
    assign fill.req_addr = {pr_tag, pr_set, {OFF_W{1'b0}}};

    // Probe tag already on its way from memory
    assign mrq_match = mrq_present[pr_set] && (mrq_tag[pr_set] == pr_tag);

    // A store goes ahead if it can pin the present line, the outstanding
    // miss, or a miss it starts now; a hit on a line about to be replaced
    // waits as well
    assign store_stall = valid && store &&
        !((hit && !mrq_present[pr_set]) || req || mrq_match);

    // Response always belongs to a tracked miss
    assign res_ok = fill.res && mrq_present[res_set];

    // Drain blocked during a fill, and waits for its line otherwise
    assign drain_ok = drain.wenable && !fill.res && (tags[sb_set] == sb_tag);
    assign drain.store_success = drain_ok;

    // Dirty victim leaves in the same cycle its replacement arrives
    assign evict      = res_ok && dirty[res_set];
    assign evict_addr = {tags[res_set], res_set, {OFF_W{1'b0}}};
    assign evict_data = data[res_set];

    // Load extraction, byte is sign extended, word is aligned
    always_comb begin
        probe_line = data[pr_set];
        load_byte  = probe_line[{pr_off, 3'b000} +: 8];
        if (load_size == SIZE_BYTE) begin
            read_data = {{(`DC_WORD_BITS - 8){load_byte[7]}}, load_byte};
        end else begin
            read_data = probe_line[{pr_off[OFF_W-1:2], 5'b00000} +: `DC_WORD_BITS];
        end
    end

    // Merge the head store into its line
    always_comb begin
        merged = data[sb_set];
        if (drain.size == SIZE_BYTE) begin
            merged[{sb_off, 3'b000} +: 8] = drain.value[7:0];
        end else begin
            merged[{sb_off[OFF_W-1:2], 5'b00000} +: `DC_WORD_BITS] = drain.value;
        end
    end

    // Per-set pin events this cycle
    always_comb begin
        pin_inc = '0;
        pin_dec = '0;
        mrq_inc = '0;
        pin_inc[pr_set] = valid && store && hit && !mrq_present[pr_set];
        mrq_inc[pr_set] = valid && store && mrq_match;
        pin_dec[sb_set] = drain_ok;
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < N; s++) begin
                // all ones keeps low addresses from hitting before a fill
                tags[s]        <= '1;
                dirty[s]       <= 1'b0;
                pin_cnt[s]     <= '0;
                mrq_present[s] <= 1'b0;
                mrq_tag[s]     <= '0;
                mrq_pin[s]     <= '0;
            end
        end else begin
            for (int s = 0; s < N; s++) begin
                if (res_ok && (res_set == SET_W'(s))) begin
                    // New line installs clean and takes over the miss pins
                    tags[s]        <= res_tag;
                    dirty[s]       <= 1'b0;
                    pin_cnt[s]     <= mrq_pin[s] + PIN_W'(mrq_inc[s]);
                    mrq_present[s] <= 1'b0;
                end else begin
                    if (pin_dec[s]) begin
                        dirty[s] <= 1'b1;
                    end
                    pin_cnt[s] <= pin_cnt[s] + PIN_W'(pin_inc[s]) - PIN_W'(pin_dec[s]);
                end

                // Open a miss, a store opens it already pinned once
                if (req && (pr_set == SET_W'(s))) begin
                    mrq_present[s] <= 1'b1;
                    mrq_tag[s]     <= pr_tag;
                    mrq_pin[s]     <= PIN_W'(store);
                end else if (mrq_inc[s]) begin
                    mrq_pin[s] <= mrq_pin[s] + 1'b1;
                end
            end
        end
    end

    // Line data, written by a fill or by a drained store
    always_ff @(posedge clk) begin
        if (res_ok) begin
            data[res_set] <= fill.res_data;
        end else if (drain_ok) begin
            data[sb_set] <= merged;
        end
    end

endmodule

// File: rtl/mem_port.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module mem_port #(
    parameter int QUEUE_DEPTH = `DC_MRQ_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    line_fill_if.port         fill,
    input  logic              evict,
    input  dcache_pkg::word_t evict_addr,
    input  dcache_pkg::line_t evict_data,
    output logic              rd_req,
    output dcache_pkg::word_t rd_addr,
    input  logic              rd_valid,
    input  dcache_pkg::line_t rd_data,
    output logic              wr_en,
    output dcache_pkg::word_t wr_addr,
    output dcache_pkg::line_t wr_data
);
    import dcache_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    // Addresses of requests still waiting for data, oldest at head
    word_t            addr_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] q_head;
    logic [PTR_W-1:0] q_tail;

    // One register stage between cache request and memory
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= fill.req;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= fill.req_addr;
        if (fill.req) begin
            addr_q[q_tail] <= fill.req_addr;
        end
    end

    // Queue pointers, never more in flight than sets
    always_ff @(posedge clk) begin
        if (rst) begin
            q_head <= '0;
            q_tail <= '0;
        end else begin
            if (fill.req) begin
                q_tail <= (q_tail == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_tail + 1'b1;
            end
            if (rd_valid) begin
                q_head <= (q_head == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : q_head + 1'b1;
            end
        end
    end

    // Memory answers in order, so data pairs with the head address
    assign fill.res      = rd_valid;
    assign fill.res_addr = addr_q[q_head];
    assign fill.res_data = rd_data;

    // Write-back goes out unregistered
    assign wr_en   = evict;
    assign wr_addr = evict_addr;
    assign wr_data = evict_data;

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    // Probe from the memory stage
    input  logic                  valid,
    input  dcache_pkg::word_t     addr,
    input  dcache_pkg::mem_size_e load_size,
    input  logic                  store,
    output logic                  hit,
    output logic                  store_stall,
    output dcache_pkg::word_t     read_data,
    // Committed stores
    input  logic                  commit,
    input  dcache_pkg::word_t     commit_addr,
    input  dcache_pkg::word_t     commit_value,
    input  dcache_pkg::mem_size_e commit_size,
    output logic                  sb_full,
    output logic                  sb_empty,
    // External memory
    output logic                  rd_req,
    output dcache_pkg::word_t     rd_addr,
    input  logic                  rd_valid,
    input  dcache_pkg::line_t     rd_data,
    output logic                  wr_en,
    output dcache_pkg::word_t     wr_addr,
    output dcache_pkg::line_t     wr_data
);
    import dcache_pkg::*;

    sb_drain_if  drain_bus ();
    line_fill_if fill_bus ();

    // Victim line towards the memory port
    logic  evict;
    word_t evict_addr;
    line_t evict_data;

    store_buffer #(
        .DEPTH (`DC_SB_ENTRIES)
    ) u_store_buffer (
        .clk          (clk),
        .rst          (rst),
        .commit       (commit),
        .commit_addr  (commit_addr),
        .commit_value (commit_value),
        .commit_size  (commit_size),
        .sb_full      (sb_full),
        .sb_empty     (sb_empty),
        .drain        (drain_bus.producer)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .addr        (addr),
        .load_size   (load_size),
        .store       (store),
        .hit         (hit),
        .store_stall (store_stall),
        .read_data   (read_data),
        .drain       (drain_bus.consumer),
        .fill        (fill_bus.cache),
        .evict       (evict),
        .evict_addr  (evict_addr),
        .evict_data  (evict_data)
    );

    mem_port #(
        .QUEUE_DEPTH (`DC_MRQ_DEPTH)
    ) u_mem_port (
        .clk        (clk),
        .rst        (rst),
        .fill       (fill_bus.port),
        .evict      (evict),
        .evict_addr (evict_addr),
        .evict_data (evict_data),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

// File: bench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int LATENCY = 4,
    parameter int LINES   = 256,
    parameter int LOG_MAX = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_req,
    input  dcache_pkg::word_t rd_addr,
    output logic              rd_valid,
    output dcache_pkg::line_t rd_data,
    input  logic              wr_en,
    input  dcache_pkg::word_t wr_addr,
    input  dcache_pkg::line_t wr_data
);
    import dcache_pkg::*;

    // Top bit of the line index inside an address
    localparam int IDX_HI = $clog2(LINES) + 3;

    // Backing store, loaded by the testbench before reset ends
    line_t lines [LINES];

    // Write-back log in arrival order
    word_t log_addr [LOG_MAX];
    line_t log_data [LOG_MAX];
    int    log_count = 0;

    // Read delay line, one slot per cycle keeps returns in request order
    logic [LATENCY-1:0] pipe_vld = '0;
    word_t              pipe_addr [LATENCY] = '{default: '0};

    always @(posedge clk) begin
        if (rst) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[LATENCY-2:0], rd_req};
        end
        pipe_addr[0] <= rd_addr;
        for (int i = 1; i < LATENCY; i++) begin
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    // Data comes out with the last slot
    assign rd_valid = pipe_vld[LATENCY-1];
    assign rd_data  = lines[pipe_addr[LATENCY-1][IDX_HI:4]];

    // Write-backs land in the store and in the log
    always @(posedge clk) begin
        if (!rst && wr_en) begin
            lines[wr_addr[IDX_HI:4]] <= wr_data;
            if (log_count < LOG_MAX) begin
                log_addr[log_count] <= wr_addr;
                log_data[log_count] <= wr_data;
            end
            log_count <= log_count + 1;
        end
    end

endmodule

// File: bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    // About 1500 cycles of traffic, limit leaves ample margin
    localparam int MAX_CYCLES  = 4000;
    localparam int RAND_OPS    = 40;
    // A store that misses needs a fill and a drain, well under this
    localparam int DRAIN_LIMIT = 16;

    logic      clk;
    logic      rst;
    logic      valid;
    word_t     addr;
    mem_size_e load_size;
    logic      store;
    logic      hit;
    logic      store_stall;
    word_t     read_data;
    logic      commit;
    word_t     commit_addr;
    word_t     commit_value;
    mem_size_e commit_size;
    logic      sb_full;
    logic      sb_empty;
    logic      rd_req;
    word_t     rd_addr;
    logic      rd_valid;
    line_t     rd_data;
    logic      wr_en;
    word_t     wr_addr;
    line_t     wr_data;

    // Byte image of memory as the program sees it
    logic [7:0] shadow [4096];
    word_t      lfsr;
    word_t      last_rd_addr = '0;
    int         checks = 0;
    int         errors = 0;
    int         err_mark = 0;
    int         cycles = 0;
    int         in_flight = 0;
    int         max_in_flight = 0;

    dcache_top uut (.*);
    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Line requests minus returns gives misses in flight
    always @(posedge clk) begin
        if (rst) begin
            in_flight = 0;
        end else begin
            in_flight = in_flight + int'(rd_req) - int'(rd_valid);
            if (in_flight > max_in_flight) max_in_flight = in_flight;
        end
    end

    // Address of the most recent line request
    always @(posedge clk) begin
        if (!rst && rd_req) begin
            last_rd_addr = rd_addr;
        end
    end

    // Every write-back must carry the program's view of the victim line
    always @(posedge clk) begin
        if (!rst && wr_en) begin
            expect_true(wr_data === shadow_line(wr_addr),
                $sformatf("write-back %h data %h", wr_addr, wr_data));
        end
    end

    // Byte i of a line is the low address byte plus i, times 7
    function automatic line_t init_line(input word_t base);
        line_t      l;
        logic [7:0] b;
        for (int i = 0; i < 16; i++) begin
            b = base[7:0] + 8'(i);
            l[8*i +: 8] = b * 8'd7;
        end
        return l;
    endfunction

    function automatic line_t shadow_line(input word_t a);
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[8*i +: 8] = shadow[{a[11:4], 4'(i)}];
        end
        return l;
    endfunction

    // Little-endian word, or byte with sign extension
    function automatic word_t ref_load(input word_t a, input mem_size_e sz);
        logic [7:0]  b;
        logic [11:0] w;
        b = shadow[a[11:0]];
        w = {a[11:2], 2'b00};
        if (sz == SIZE_BYTE) return {{24{b[7]}}, b};
        return {shadow[w + 12'd3], shadow[w + 12'd2], shadow[w + 12'd1], shadow[w]};
    endfunction

    // Fibonacci taps 32, 22, 2, 1
    function automatic word_t lfsr_step(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output word_t r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("[ERROR] %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d, %s: %s", num, name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    // Probe is held until hit, data checked in that first hit cycle
    task automatic load_op(input word_t a, input mem_size_e sz, output int lat);
        word_t exp;
        logic  done;
        @(negedge clk);
        valid = 1'b1;
        store = 1'b0;
        addr = a;
        load_size = sz;
        lat = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (hit) begin
                exp = ref_load(a, sz);
                expect_true(read_data === exp,
                    $sformatf("load %h expected %h got %h", a, exp, read_data));
                done = 1'b1;
            end else begin
                lat++;
            end
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    // Store probe repeats while stalled, then the store is committed
    task automatic store_op(input word_t a, input word_t v, input mem_size_e sz,
                            output int stalls);
        logic done;
        @(negedge clk);
        valid = 1'b1;
        store = 1'b1;
        addr = a;
        load_size = sz;
        stalls = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (store_stall) stalls++;
            else done = 1'b1;
        end
        @(negedge clk);
        valid = 1'b0;
        store = 1'b0;
        while (sb_full) @(negedge clk);
        commit = 1'b1;
        commit_addr = a;
        commit_value = v;
        commit_size = sz;
        if (sz == SIZE_BYTE) begin
            shadow[a[11:0]] = v[7:0];
        end else begin
            for (int i = 0; i < 4; i++) shadow[{a[11:2], 2'(i)}] = v[8*i +: 8];
        end
        @(negedge clk);
        commit = 1'b0;
    endtask

    // Store buffer must empty within a bounded number of cycles
    task automatic wait_drain();
        int n;
        n = 0;
        while (!sb_empty && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        expect_true(sb_empty,
            $sformatf("store buffer still holds stores after %0d cycles", n));
    endtask

    initial begin
        int    lat;
        int    stalls;
        int    wb_before;
        word_t r;
        word_t a;
        word_t v;
        word_t burst [4];
        line_t init_l;

        rst = 1'b1;
        valid = 1'b0;
        addr = '0;
        load_size = SIZE_WORD;
        store = 1'b0;
        commit = 1'b0;
        commit_addr = '0;
        commit_value = '0;
        commit_size = SIZE_WORD;
        lfsr = 32'hcfb7;
        for (int i = 0; i < 256; i++) begin
            init_l = init_line(word_t'(i * 16));
            u_mem.lines[i] = init_l;
            for (int j = 0; j < 16; j++) begin
                shadow[i*16 + j] = init_l[8*j +: 8];
            end
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // 1. Reset state, a cold miss, then a hit on the same line
        expect_true(!rd_req && !wr_en && !hit && !store_stall, "outputs active after reset");
        expect_true(!sb_full && sb_empty, "store buffer flags wrong after reset");
        load_op(32'h100, SIZE_WORD, lat);
        expect_true(lat == 6, $sformatf("miss took %0d cycles, expected 6", lat));
        expect_true(last_rd_addr === 32'h100,
            $sformatf("line request address %h, expected 100", last_rd_addr));
        load_op(32'h108, SIZE_WORD, lat);
        expect_true(lat == 0, $sformatf("second load waited %0d cycles", lat));
        end_test(1, "miss then hit");

        // 2. Byte 0x13 times 7 has the sign bit set, 0x11 times 7 does not
        load_op(32'h113, SIZE_BYTE, lat);
        load_op(32'h111, SIZE_BYTE, lat);
        end_test(2, "byte sign extension");

        // 3. Word and byte stores into a present line
        store_op(32'h104, 32'hdeadbeef, SIZE_WORD, stalls);
        store_op(32'h10a, 32'h0000009c, SIZE_BYTE, stalls);
        wait_drain();
        load_op(32'h104, SIZE_WORD, lat);
        load_op(32'h10a, SIZE_BYTE, lat);
        load_op(32'h108, SIZE_WORD, lat);
        end_test(3, "store drain and merge");

        // 4. Conflict miss in set 0 pushes out the dirty line 0x100
        wb_before = u_mem.log_count;
        load_op(32'h200, SIZE_WORD, lat);
        expect_true(last_rd_addr === 32'h200,
            $sformatf("line request address %h, expected 200", last_rd_addr));
        expect_true(u_mem.log_count == wb_before + 1, "no write-back of the dirty line");
        expect_true(u_mem.log_addr[wb_before] === 32'h100,
            $sformatf("write-back address %h, expected 100", u_mem.log_addr[wb_before]));
        expect_true(u_mem.log_data[wb_before] === shadow_line(32'h100),
            $sformatf("logged line %h", u_mem.log_data[wb_before]));
        load_op(32'h104, SIZE_WORD, lat);
        end_test(4, "dirty eviction");

        // 5. One-cycle load probe opens a miss, the store to another tag waits
        @(negedge clk);
        valid = 1'b1;
        store = 1'b0;
        addr = 32'h320;
        load_size = SIZE_WORD;
        store_op(32'h420, 32'h12345678, SIZE_WORD, stalls);
        expect_true(stalls > 0, "store to a set with another outstanding tag did not stall");
        wait_drain();
        load_op(32'h420, SIZE_WORD, lat);
        end_test(5, "store stall");

        // 6. Burst of misses to all sets in the untouched upper region
        max_in_flight = 0;
        for (int s = 0; s < 4; s++) begin
            draw_bits(5, r);
            burst[s] = 32'h800 | (r << 6) | word_t'(s << 4);
            @(negedge clk);
            valid = 1'b1;
            store = 1'b0;
            addr = burst[s];
            load_size = SIZE_WORD;
        end
        @(negedge clk);
        valid = 1'b0;
        for (int s = 0; s < 4; s++) load_op(burst[s], SIZE_WORD, lat);
        expect_true(max_in_flight == 4,
            $sformatf("%0d misses in flight, expected 4", max_in_flight));
        for (int k = 0; k < RAND_OPS; k++) begin
            draw_bits(12, a);
            draw_bits(2, r);
            // Words are aligned
            if (r[1]) a[1:0] = 2'b00;
            if (r[0]) begin
                draw_bits(32, v);
                store_op(a, v, r[1] ? SIZE_WORD : SIZE_BYTE, stalls);
                wait_drain();
            end else begin
                load_op(a, r[1] ? SIZE_WORD : SIZE_BYTE, lat);
            end
        end
        end_test(6, "random traffic");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ifc.sv
rtl/store_buffer.sv
rtl/dcache.sv
rtl/mem_port.sv
rtl/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv
